//--- hdl/branch_unit.sv
`timescale 1ns/1ns
`include "id_config.svh"

module branch_unit
    import id_pkg::*;
(
    input  decode_t dec_i,
    input  data_t   pc_i,
    input  data_t   reg1_i,
    input  data_t   reg2_i,
    input  logic    stall_i,
    output logic    branch_o,
    output data_t   target_o,
    output data_t   link_data_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic taken;

    assign eq   = (reg1_i == reg2_i);
    assign lt_s = ($signed(reg1_i) < $signed(reg2_i));
    assign lt_u = (reg1_i < reg2_i);

    always_comb begin
        case (dec_i.branch)
            BR_EQ:             taken = eq;
            BR_NE:             taken = !eq;
            BR_LT:             taken = lt_s;
            BR_GE:             taken = !lt_s;
            BR_LTU:            taken = lt_u;
            BR_GEU:            taken = !lt_u;
            BR_ALWAYS, BR_REG: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    // Operands are not final while a load-use stall is pending
    assign branch_o = taken && !stall_i;

    // jirl is relative to rj
    assign target_o    = ((dec_i.branch == BR_REG) ? reg1_i : pc_i) + dec_i.offset;
    assign link_data_o = pc_i + data_t'(`INST_BYTES);

endmodule

//--- hdl/id_config.svh
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

`define INST_W      32
`define DATA_W      32
`define REG_ADDR_W  5
`define LINK_REG    1
`define INST_BYTES  4

// 10-bit opcodes, inst[31:22]
`define OP10_SLTI    10'h008
`define OP10_SLTUI   10'h009
`define OP10_ADDI_W  10'h00a
`define OP10_ANDI    10'h00d
`define OP10_ORI     10'h00e
`define OP10_XORI    10'h00f
`define OP10_LD_B    10'h0a0
`define OP10_LD_H    10'h0a1
`define OP10_LD_W    10'h0a2
`define OP10_ST_B    10'h0a4
`define OP10_ST_H    10'h0a5
`define OP10_ST_W    10'h0a6
`define OP10_LD_BU   10'h0a8
`define OP10_LD_HU   10'h0a9

// 17-bit opcodes, inst[31:15]
`define OP17_ADD_W   17'h00020
`define OP17_SUB_W   17'h00022
`define OP17_SLT     17'h00024
`define OP17_SLTU    17'h00025
`define OP17_NOR     17'h00028
`define OP17_AND     17'h00029
`define OP17_OR      17'h0002a
`define OP17_XOR     17'h0002b
`define OP17_SLL_W   17'h0002e
`define OP17_SRL_W   17'h0002f
`define OP17_SRA_W   17'h00030
`define OP17_SLLI_W  17'h00081
`define OP17_SRLI_W  17'h00089
`define OP17_SRAI_W  17'h00091

// 7-bit opcodes, inst[31:25]
`define OP7_LU12I_W  7'h0a

// 6-bit opcodes, inst[31:26]
`define OP6_JIRL     6'h13
`define OP6_B        6'h14
`define OP6_BL       6'h15
`define OP6_BEQ      6'h16
`define OP6_BNE      6'h17
`define OP6_BLT      6'h18
`define OP6_BGE      6'h19
`define OP6_BLTU     6'h1a
`define OP6_BGEU     6'h1b

`endif

//--- hdl/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  decode_t   dec_i,
    input  data_t     reg1_i,
    input  data_t     reg2_i,
    input  data_t     link_data_i,
    output logic      stall_o,
    output logic      ex_fwd_en_o,
    output reg_addr_t ex_fwd_addr_o,
    output ex_ctrl_t  ex_ctrl_o
);

    logic ex_is_load;
    logic rd1_dep;
    logic rd2_dep;

    // Load data is not ready until MEM
    assign ex_is_load = ex_ctrl_o.valid && ex_ctrl_o.is_load;
    assign rd1_dep    = dec_i.rd1_en && (dec_i.rd1_addr == ex_ctrl_o.wr_addr);
    assign rd2_dep    = dec_i.rd2_en && (dec_i.rd2_addr == ex_ctrl_o.wr_addr);
    assign stall_o    = ex_is_load && (rd1_dep || rd2_dep);

    assign ex_fwd_en_o   = ex_ctrl_o.valid && ex_ctrl_o.we;
    assign ex_fwd_addr_o = ex_ctrl_o.wr_addr;

    always_ff @(posedge clk) begin
        if (rst || stall_o) begin
            // Bubble
            ex_ctrl_o.valid   <= 1'b0;
            ex_ctrl_o.aluop   <= ALU_NOP;
            ex_ctrl_o.alusel  <= SEL_NOP;
            ex_ctrl_o.we      <= 1'b0;
            ex_ctrl_o.is_load <= 1'b0;
        end else begin
            ex_ctrl_o.valid   <= dec_i.valid;
            ex_ctrl_o.aluop   <= dec_i.aluop;
            ex_ctrl_o.alusel  <= dec_i.alusel;
            ex_ctrl_o.we      <= dec_i.we;
            ex_ctrl_o.is_load <= dec_i.is_load;
        end
    end

    always_ff @(posedge clk) begin
        ex_ctrl_o.reg1      <= reg1_i;
        ex_ctrl_o.reg2      <= reg2_i;
        ex_ctrl_o.wr_addr   <= dec_i.wr_addr;
        ex_ctrl_o.link_data <= link_data_i;
    end

endmodule

//--- hdl/id_pkg.sv
`include "id_config.svh"

package id_pkg;

    typedef logic [`INST_W-1:0]     inst_t;
    typedef logic [`DATA_W-1:0]     data_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [5:0] {
        ALU_NOP,
        ALU_ADD_W, ALU_SUB_W, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL_W, ALU_SRL_W, ALU_SRA_W,
        ALU_ADDI_W, ALU_SLTI, ALU_SLTUI, ALU_ANDI, ALU_ORI, ALU_XORI,
        ALU_SLLI_W, ALU_SRLI_W, ALU_SRAI_W, ALU_LU12I_W,
        ALU_LD_B, ALU_LD_H, ALU_LD_W, ALU_LD_BU, ALU_LD_HU,
        ALU_ST_B, ALU_ST_H, ALU_ST_W,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_B, ALU_BL, ALU_JIRL
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_LOAD_STORE, SEL_BRANCH
    } alu_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS, BR_REG
    } branch_e;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        logic      rd1_en;
        reg_addr_t rd1_addr;
        logic      rd2_en;
        reg_addr_t rd2_addr;
        logic      we;
        reg_addr_t wr_addr;
        data_t     imm;
        branch_e   branch;
        data_t     offset;
        logic      link;
        logic      valid;
        logic      is_load;
    } decode_t;

    // Write-back bypass from a later stage
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        data_t     data;
    } fwd_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   aluop;
        alu_sel_e  alusel;
        data_t     reg1;
        data_t     reg2;
        logic      we;
        reg_addr_t wr_addr;
        data_t     link_data;
        logic      is_load;
    } ex_ctrl_t;

endpackage

//--- hdl/id_stage.sv
`timescale 1ns/1ns

module id_stage
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  data_t     pc_i,
    input  inst_t     inst_i,
    output logic      rd1_en_o,
    output logic      rd2_en_o,
    output reg_addr_t rd1_addr_o,
    output reg_addr_t rd2_addr_o,
    input  data_t     rd1_data_i,
    input  data_t     rd2_data_i,
    input  data_t     ex_result_i,
    input  fwd_t      mem_fwd_i,
    output logic      pause_o,
    output logic      branch_o,
    output logic      flush_o,
    output data_t     target_o,
    output ex_ctrl_t  ex_ctrl_o
);

    decode_t   dec;
    data_t     reg1;
    data_t     reg2;
    data_t     link_data;
    fwd_t      ex_fwd;
    logic      stall;
    logic      ex_fwd_en;
    reg_addr_t ex_fwd_addr;

    assign rd1_en_o   = dec.rd1_en;
    assign rd1_addr_o = dec.rd1_addr;
    assign rd2_en_o   = dec.rd2_en;
    assign rd2_addr_o = dec.rd2_addr;
    assign pause_o    = stall;
    assign flush_o    = branch_o;

    // EX bypass from the held ID/EX contents
    assign ex_fwd.we   = ex_fwd_en;
    assign ex_fwd.addr = ex_fwd_addr;
    assign ex_fwd.data = ex_result_i;

    inst_decoder u_inst_decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    operand_mux u_operand_mux_1 (
        .read_en_i   (dec.rd1_en),
        .read_addr_i (dec.rd1_addr),
        .imm_i       (dec.imm),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd_i),
        .rf_data_i   (rd1_data_i),
        .operand_o   (reg1)
    );

    operand_mux u_operand_mux_2 (
        .read_en_i   (dec.rd2_en),
        .read_addr_i (dec.rd2_addr),
        .imm_i       (dec.imm),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd_i),
        .rf_data_i   (rd2_data_i),
        .operand_o   (reg2)
    );

    branch_unit u_branch_unit (
        .dec_i       (dec),
        .pc_i        (pc_i),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .stall_i     (stall),
        .branch_o    (branch_o),
        .target_o    (target_o),
        .link_data_o (link_data)
    );

    id_ex_reg u_id_ex_reg (
        .clk           (clk),
        .rst           (rst),
        .dec_i         (dec),
        .reg1_i        (reg1),
        .reg2_i        (reg2),
        .link_data_i   (link_data),
        .stall_o       (stall),
        .ex_fwd_en_o   (ex_fwd_en),
        .ex_fwd_addr_o (ex_fwd_addr),
        .ex_ctrl_o     (ex_ctrl_o)
    );

endmodule

//--- hdl/inst_decoder.sv
`timescale 1ns/1ns
`include "id_config.svh"

module inst_decoder
    import id_pkg::*;
(
    input  inst_t   inst_i,
    output decode_t dec_o
);

    logic [9:0]  op10;
    logic [16:0] op17;
    logic [6:0]  op7;
    logic [5:0]  op6;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    data_t       si12;
    data_t       ui12;
    data_t       ui5;
    data_t       lu12i_imm;
    data_t       off16;
    data_t       off26;
    alu_op_e     aluop;
    logic        known;

    assign op10 = inst_i[31:22];
    assign op17 = inst_i[31:15];
    assign op7  = inst_i[31:25];
    assign op6  = inst_i[31:26];
    assign rd   = inst_i[4:0];
    assign rj   = inst_i[9:5];
    assign rk   = inst_i[14:10];

    assign si12      = {{(`DATA_W-12){inst_i[21]}}, inst_i[21:10]};
    assign ui12      = {{(`DATA_W-12){1'b0}}, inst_i[21:10]};
    assign ui5       = {{(`DATA_W-5){1'b0}}, inst_i[14:10]};
    assign lu12i_imm = {inst_i[24:5], 12'b0};
    // Branch offsets are word counts
    assign off16 = {{(`DATA_W-18){inst_i[25]}}, inst_i[25:10], 2'b00};
    assign off26 = {{(`DATA_W-28){inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    // Field widths never overlap for kept encodings
    always_comb begin
        aluop = ALU_NOP;
        case (op10)
            `OP10_SLTI:   aluop = ALU_SLTI;
            `OP10_SLTUI:  aluop = ALU_SLTUI;
            `OP10_ADDI_W: aluop = ALU_ADDI_W;
            `OP10_ANDI:   aluop = ALU_ANDI;
            `OP10_ORI:    aluop = ALU_ORI;
            `OP10_XORI:   aluop = ALU_XORI;
            `OP10_LD_B:   aluop = ALU_LD_B;
            `OP10_LD_H:   aluop = ALU_LD_H;
            `OP10_LD_W:   aluop = ALU_LD_W;
            `OP10_LD_BU:  aluop = ALU_LD_BU;
            `OP10_LD_HU:  aluop = ALU_LD_HU;
            `OP10_ST_B:   aluop = ALU_ST_B;
            `OP10_ST_H:   aluop = ALU_ST_H;
            `OP10_ST_W:   aluop = ALU_ST_W;
            default: ;
        endcase
        case (op17)
            `OP17_ADD_W:  aluop = ALU_ADD_W;
            `OP17_SUB_W:  aluop = ALU_SUB_W;
            `OP17_SLT:    aluop = ALU_SLT;
            `OP17_SLTU:   aluop = ALU_SLTU;
            `OP17_NOR:    aluop = ALU_NOR;
            `OP17_AND:    aluop = ALU_AND;
            `OP17_OR:     aluop = ALU_OR;
            `OP17_XOR:    aluop = ALU_XOR;
            `OP17_SLL_W:  aluop = ALU_SLL_W;
            `OP17_SRL_W:  aluop = ALU_SRL_W;
            `OP17_SRA_W:  aluop = ALU_SRA_W;
            `OP17_SLLI_W: aluop = ALU_SLLI_W;
            `OP17_SRLI_W: aluop = ALU_SRLI_W;
            `OP17_SRAI_W: aluop = ALU_SRAI_W;
            default: ;
        endcase
        if (op7 == `OP7_LU12I_W) begin
            aluop = ALU_LU12I_W;
        end
        case (op6)
            `OP6_JIRL: aluop = ALU_JIRL;
            `OP6_B:    aluop = ALU_B;
            `OP6_BL:   aluop = ALU_BL;
            `OP6_BEQ:  aluop = ALU_BEQ;
            `OP6_BNE:  aluop = ALU_BNE;
            `OP6_BLT:  aluop = ALU_BLT;
            `OP6_BGE:  aluop = ALU_BGE;
            `OP6_BLTU: aluop = ALU_BLTU;
            `OP6_BGEU: aluop = ALU_BGEU;
            default: ;
        endcase
    end

    assign known = (aluop != ALU_NOP);

    always_comb begin
        // Most kept instructions read rj and write rd
        dec_o          = '0;
        dec_o.aluop    = aluop;
        dec_o.valid    = known;
        dec_o.rd1_en   = known;
        dec_o.rd1_addr = rj;
        dec_o.rd2_addr = rk;
        dec_o.we       = known;
        dec_o.wr_addr  = rd;
        case (aluop)
            ALU_ADD_W, ALU_SUB_W, ALU_SLT, ALU_SLTU: begin
                dec_o.alusel = SEL_ARITH;
                dec_o.rd2_en = 1'b1;
            end
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: begin
                dec_o.alusel = SEL_LOGIC;
                dec_o.rd2_en = 1'b1;
            end
            ALU_SLL_W, ALU_SRL_W, ALU_SRA_W: begin
                dec_o.alusel = SEL_SHIFT;
                dec_o.rd2_en = 1'b1;
            end
            ALU_ADDI_W, ALU_SLTI, ALU_SLTUI: begin
                dec_o.alusel = SEL_ARITH;
                dec_o.imm    = si12;
            end
            ALU_ANDI, ALU_ORI, ALU_XORI: begin
                dec_o.alusel = SEL_LOGIC;
                dec_o.imm    = ui12;
            end
            ALU_SLLI_W, ALU_SRLI_W, ALU_SRAI_W: begin
                dec_o.alusel = SEL_SHIFT;
                dec_o.imm    = ui5;
            end
            ALU_LU12I_W: begin
                dec_o.alusel   = SEL_LOGIC;
                dec_o.rd1_addr = '0;
                dec_o.imm      = lu12i_imm;
            end
            ALU_LD_B, ALU_LD_H, ALU_LD_W, ALU_LD_BU, ALU_LD_HU: begin
                dec_o.alusel  = SEL_LOAD_STORE;
                dec_o.imm     = si12;
                dec_o.is_load = 1'b1;
            end
            ALU_ST_B, ALU_ST_H, ALU_ST_W: begin
                // Store data comes from rd
                dec_o.alusel   = SEL_LOAD_STORE;
                dec_o.imm      = si12;
                dec_o.rd2_en   = 1'b1;
                dec_o.rd2_addr = rd;
                dec_o.we       = 1'b0;
            end
            ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: begin
                dec_o.alusel   = SEL_BRANCH;
                dec_o.rd2_en   = 1'b1;
                dec_o.rd2_addr = rd;
                dec_o.we       = 1'b0;
                dec_o.offset   = off16;
                case (aluop)
                    ALU_BEQ: dec_o.branch = BR_EQ;
                    ALU_BNE: dec_o.branch = BR_NE;
                    ALU_BLT: dec_o.branch = BR_LT;
                    ALU_BGE: dec_o.branch = BR_GE;
                    ALU_BLTU: dec_o.branch = BR_LTU;
                    default: dec_o.branch = BR_GEU;
                endcase
            end
            ALU_B, ALU_BL: begin
                dec_o.alusel  = SEL_BRANCH;
                dec_o.rd1_en  = 1'b0;
                dec_o.we      = (aluop == ALU_BL);
                dec_o.wr_addr = reg_addr_t'(`LINK_REG);
                dec_o.link    = (aluop == ALU_BL);
                dec_o.branch  = BR_ALWAYS;
                dec_o.offset  = off26;
            end
            ALU_JIRL: begin
                dec_o.alusel = SEL_BRANCH;
                dec_o.link   = 1'b1;
                dec_o.branch = BR_REG;
                dec_o.offset = off16;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/operand_mux.sv
`timescale 1ns/1ns

module operand_mux
    import id_pkg::*;
(
    input  logic      read_en_i,
    input  reg_addr_t read_addr_i,
    input  data_t     imm_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    input  data_t     rf_data_i,
    output data_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.addr == read_addr_i);
    assign mem_hit = mem_fwd_i.we && (mem_fwd_i.addr == read_addr_i);

    // Youngest result wins
    always_comb begin
        if (!read_en_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.data;
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.data;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f sim.f --top-module id_stage_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vid_stage_tb 2>&1 | tee "$log"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

//--- sim.f
+incdir+hdl
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/operand_mux.sv
hdl/branch_unit.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
verif/tb_clk_gen.sv
verif/id_stage_sva.sv
verif/id_stage_tb.sv

//--- verif/id_stage_sva.sv
`timescale 1ns/1ns
`include "id_config.svh"

module id_stage_sva
    import id_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input inst_t    inst_i,
    input logic     pause_i,
    input logic     flush_i,
    input ex_ctrl_t ex_ctrl_i
);

    // Only a branch opcode may redirect fetch
    flush_needs_branch: assert property (
        @(posedge clk) disable iff (rst)
            flush_i |-> ((inst_i[31:26] >= `OP6_JIRL) && (inst_i[31:26] <= `OP6_BGEU))
    ) else $error("flush_o raised for an instruction that is not a branch");

    // The bubble clears the hazard
    stall_lasts_one_cycle: assert property (
        @(posedge clk) disable iff (rst) pause_i |=> !pause_i
    ) else $error("load-use stall lasted more than one cycle");

    // Bubble first, then the held instruction
    stall_then_accept: assert property (
        @(posedge clk) disable iff (rst) pause_i |=> !ex_ctrl_i.valid ##1 ex_ctrl_i.valid
    ) else $error("held instruction did not follow the bubble into EX");

endmodule

//--- verif/id_stage_tb.sv
`timescale 1ns/1ns
`include "id_config.svh"

module id_stage_tb
    import id_pkg::*;
();

    localparam inst_t nop_inst = '0;
    localparam data_t base_pc  = 32'h1c00_0100;
    // Tests take about 115 cycles
    localparam int max_cycles = 400;

    logic      clk;
    logic      rst;
    data_t     pc_i;
    inst_t     inst_i;
    logic      rd1_en_o;
    logic      rd2_en_o;
    reg_addr_t rd1_addr_o;
    reg_addr_t rd2_addr_o;
    data_t     rd1_data_i;
    data_t     rd2_data_i;
    data_t     ex_result_i;
    fwd_t      mem_fwd_i;
    logic      pause_o;
    logic      branch_o;
    logic      flush_o;
    data_t     target_o;
    ex_ctrl_t  ex_ctrl_o;

    logic [31:0] seed = 32'h1757;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    tb_clk_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    id_stage u_id_stage (
        .clk         (clk),
        .rst         (rst),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .rd1_en_o    (rd1_en_o),
        .rd2_en_o    (rd2_en_o),
        .rd1_addr_o  (rd1_addr_o),
        .rd2_addr_o  (rd2_addr_o),
        .rd1_data_i  (rd1_data_i),
        .rd2_data_i  (rd2_data_i),
        .ex_result_i (ex_result_i),
        .mem_fwd_i   (mem_fwd_i),
        .pause_o     (pause_o),
        .branch_o    (branch_o),
        .flush_o     (flush_o),
        .target_o    (target_o),
        .ex_ctrl_o   (ex_ctrl_o)
    );

    bind id_stage id_stage_sva u_id_stage_sva (
        .clk       (clk),
        .rst       (rst),
        .inst_i    (inst_i),
        .pause_i   (pause_o),
        .flush_i   (flush_o),
        .ex_ctrl_i (ex_ctrl_o)
    );

    // Register file model with one fixed value per register
    function automatic data_t rf_value(input reg_addr_t idx);
        if (idx == '0) begin
            return '0;
        end
        return 32'hc0de_0000 + {27'd0, idx} * 32'h0000_0111;
    endfunction

    assign rd1_data_i = rf_value(rd1_addr_o);
    assign rd2_data_i = rf_value(rd2_addr_o);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic data_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // Branch offsets count words
    function automatic data_t sext16(input logic [15:0] off);
        return {{14{off[15]}}, off, 2'b00};
    endfunction

    function automatic data_t sext26(input logic [25:0] off);
        return {{4{off[25]}}, off, 2'b00};
    endfunction

    function automatic logic branch_rule(input logic [5:0] op, input data_t a, input data_t b);
        case (op)
            `OP6_BEQ:  return a == b;
            `OP6_BNE:  return a != b;
            `OP6_BLT:  return $signed(a) < $signed(b);
            `OP6_BGE:  return $signed(a) >= $signed(b);
            `OP6_BLTU: return a < b;
            default:   return a >= b;
        endcase
    endfunction

    function automatic fwd_t make_fwd(input logic we, input reg_addr_t addr, input data_t data);
        fwd_t f;
        f.we   = we;
        f.addr = addr;
        f.data = data;
        return f;
    endfunction

    // addi.w rd, r0, 1
    function automatic inst_t write_inst(input reg_addr_t rd);
        return {`OP10_ADDI_W, 12'h001, 5'd0, rd};
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Inputs change on the falling edge and settle well before the rising edge
    task automatic drive_id(input data_t pc, input inst_t inst,
                            input data_t exr = '0, input fwd_t mem = '0);
        @(negedge clk);
        pc_i        = pc;
        inst_i      = inst;
        ex_result_i = exr;
        mem_fwd_i   = mem;
        #5;
    endtask

    task automatic verify_ex_ctrl(input alu_op_e op, input alu_sel_e sel, input logic we,
                                  input reg_addr_t wr, input data_t r1, input data_t r2);
        compare("ex_ctrl_o.valid", 32'(ex_ctrl_o.valid), 32'd1);
        compare("ex_ctrl_o.aluop", 32'(ex_ctrl_o.aluop), 32'(op));
        compare("ex_ctrl_o.alusel", 32'(ex_ctrl_o.alusel), 32'(sel));
        compare("ex_ctrl_o.we", 32'(ex_ctrl_o.we), 32'(we));
        if (we) begin
            compare("ex_ctrl_o.wr_addr", 32'(ex_ctrl_o.wr_addr), 32'(wr));
        end
        compare("ex_ctrl_o.reg1", ex_ctrl_o.reg1, r1);
        compare("ex_ctrl_o.reg2", ex_ctrl_o.reg2, r2);
    endtask

    task automatic verify_link(input reg_addr_t wr, input data_t pc);
        compare("ex_ctrl_o.valid", 32'(ex_ctrl_o.valid), 32'd1);
        compare("ex_ctrl_o.we", 32'(ex_ctrl_o.we), 32'd1);
        compare("ex_ctrl_o.wr_addr", 32'(ex_ctrl_o.wr_addr), 32'(wr));
        compare("ex_ctrl_o.link_data", ex_ctrl_o.link_data, pc + 32'd4);
    endtask

    task automatic reset_test;
        // A load reading its own destination stalls unless reset cleared EX
        inst_i = {`OP10_LD_W, 12'h000, 5'd9, 5'd9};
        wait (rst === 1'b0);
        #5;
        compare("ex_ctrl_o.valid", 32'(ex_ctrl_o.valid), 32'd0);
        compare("pause_o", 32'(pause_o), 32'd0);
        compare("flush_o", 32'(flush_o), 32'd0);
    endtask

    task automatic alu_imm_test;
        logic [16:0] ops [6];
        alu_op_e     exp_op [6];
        alu_sel_e    exp_sel [6];
        reg_addr_t   rj;
        reg_addr_t   rk;
        reg_addr_t   rd;
        int          i;
        ops     = '{`OP17_ADD_W, `OP17_SUB_W, `OP17_SLTU, `OP17_XOR, `OP17_NOR, `OP17_SRA_W};
        exp_op  = '{ALU_ADD_W, ALU_SUB_W, ALU_SLTU, ALU_XOR, ALU_NOR, ALU_SRA_W};
        exp_sel = '{SEL_ARITH, SEL_ARITH, SEL_ARITH, SEL_LOGIC, SEL_LOGIC, SEL_SHIFT};
        drive_id(base_pc, nop_inst);
        for (i = 0; i < 6; i++) begin
            seed = xorshift(seed);
            rj   = seed[4:0];
            rk   = seed[9:5];
            rd   = seed[14:10];
            drive_id(base_pc, {ops[i], rk, rj, rd});
            compare("rd1_en_o", 32'(rd1_en_o), 32'd1);
            compare("rd1_addr_o", 32'(rd1_addr_o), 32'(rj));
            compare("rd2_addr_o", 32'(rd2_addr_o), 32'(rk));
            compare("rd2_en_o", 32'(rd2_en_o), 32'd1);
            drive_id(base_pc, nop_inst);
            verify_ex_ctrl(exp_op[i], exp_sel[i], 1'b1, rd, rf_value(rj), rf_value(rk));
        end
        drive_id(base_pc, {`OP10_ADDI_W, 12'hffb, 5'd7, 5'd6});
        drive_id(base_pc, nop_inst);
        verify_ex_ctrl(ALU_ADDI_W, SEL_ARITH, 1'b1, 5'd6, rf_value(5'd7), sext12(12'hffb));
        // Logic immediates are zero-extended
        drive_id(base_pc, {`OP10_ANDI, 12'h8f0, 5'd9, 5'd8});
        drive_id(base_pc, nop_inst);
        verify_ex_ctrl(ALU_ANDI, SEL_LOGIC, 1'b1, 5'd8, rf_value(5'd9), 32'h0000_08f0);
        drive_id(base_pc, {`OP17_SLLI_W, 5'd17, 5'd11, 5'd10});
        drive_id(base_pc, nop_inst);
        verify_ex_ctrl(ALU_SLLI_W, SEL_SHIFT, 1'b1, 5'd10, rf_value(5'd11), 32'd17);
        // lu12i.w takes r0 as its first operand
        drive_id(base_pc, {`OP7_LU12I_W, 20'habcde, 5'd12});
        drive_id(base_pc, nop_inst);
        verify_ex_ctrl(ALU_LU12I_W, SEL_LOGIC, 1'b1, 5'd12, 32'd0, 32'habcd_e000);
        drive_id(base_pc, 32'hffff_ffff);
        drive_id(base_pc, nop_inst);
        compare("ex_ctrl_o.valid", 32'(ex_ctrl_o.valid), 32'd0);
        compare("ex_ctrl_o.we", 32'(ex_ctrl_o.we), 32'd0);
    endtask

    task automatic store_test;
        logic [9:0]  ops [3];
        alu_op_e     exp_op [3];
        reg_addr_t   rj;
        reg_addr_t   rd;
        logic [11:0] imm;
        int          i;
        ops    = '{`OP10_ST_B, `OP10_ST_H, `OP10_ST_W};
        exp_op = '{ALU_ST_B, ALU_ST_H, ALU_ST_W};
        drive_id(base_pc, nop_inst);
        for (i = 0; i < 3; i++) begin
            seed = xorshift(seed);
            rj   = seed[4:0];
            rd   = seed[9:5];
            imm  = seed[21:10];
            drive_id(base_pc, {ops[i], imm, rj, rd});
            compare("rd2_addr_o", 32'(rd2_addr_o), 32'(rd));
            compare("rd2_en_o", 32'(rd2_en_o), 32'd1);
            drive_id(base_pc, nop_inst);
            verify_ex_ctrl(exp_op[i], SEL_LOAD_STORE, 1'b0, rd, rf_value(rj), rf_value(rd));
        end
    endtask

    task automatic forward_test;
        data_t ex_val;
        data_t mem_val;
        inst_t add_inst;
        seed     = xorshift(seed);
        ex_val   = seed;
        seed     = xorshift(seed);
        mem_val  = seed;
        add_inst = {`OP17_ADD_W, 5'd7, 5'd5, 5'd6};
        drive_id(base_pc, nop_inst);
        drive_id(base_pc, write_inst(5'd5));
        drive_id(base_pc, add_inst, ex_val, make_fwd(1'b1, 5'd7, mem_val));
        drive_id(base_pc, nop_inst);
        verify_ex_ctrl(ALU_ADD_W, SEL_ARITH, 1'b1, 5'd6, ex_val, mem_val);
        // The younger EX result wins when EX and MEM both hold r5
        drive_id(base_pc, write_inst(5'd5));
        drive_id(base_pc, add_inst, ex_val, make_fwd(1'b1, 5'd5, mem_val));
        drive_id(base_pc, nop_inst);
        verify_ex_ctrl(ALU_ADD_W, SEL_ARITH, 1'b1, 5'd6, ex_val, rf_value(5'd7));
        drive_id(base_pc, add_inst, ex_val, make_fwd(1'b1, 5'd5, mem_val));
        drive_id(base_pc, nop_inst);
        verify_ex_ctrl(ALU_ADD_W, SEL_ARITH, 1'b1, 5'd6, mem_val, rf_value(5'd7));
        // r0 forwards like any other register
        drive_id(base_pc, write_inst(5'd0));
        drive_id(base_pc, {`OP17_ADD_W, 5'd7, 5'd0, 5'd6}, ex_val);
        drive_id(base_pc, nop_inst);
        verify_ex_ctrl(ALU_ADD_W, SEL_ARITH, 1'b1, 5'd6, ex_val, rf_value(5'd7));
    endtask

    task automatic load_use_test;
        inst_t ld_inst;
        inst_t use_inst;
        inst_t beq_inst;
        data_t load_val;
        seed     = xorshift(seed);
        load_val = seed;
        ld_inst  = {`OP10_LD_W, 12'h004, 5'd10, 5'd9};
        use_inst = {`OP17_ADD_W, 5'd12, 5'd9, 5'd11};
        beq_inst = {`OP6_BEQ, 16'h0010, 5'd2, 5'd9};
        drive_id(base_pc, nop_inst);
        drive_id(base_pc, ld_inst);
        drive_id(base_pc, use_inst, 32'hdead_0001);
        compare("pause_o", 32'(pause_o), 32'd1);
        compare("ex_ctrl_o.is_load", 32'(ex_ctrl_o.is_load), 32'd1);
        // Held instruction sees the load data in MEM
        drive_id(base_pc, use_inst, 32'hdead_0001, make_fwd(1'b1, 5'd9, load_val));
        compare("ex_ctrl_o.valid", 32'(ex_ctrl_o.valid), 32'd0);
        compare("pause_o", 32'(pause_o), 32'd0);
        drive_id(base_pc, nop_inst);
        verify_ex_ctrl(ALU_ADD_W, SEL_ARITH, 1'b1, 5'd11, load_val, rf_value(5'd12));
        // Stale operands would compare equal here
        drive_id(base_pc, ld_inst);
        drive_id(base_pc, beq_inst, rf_value(5'd2));
        compare("pause_o", 32'(pause_o), 32'd1);
        compare("branch_o", 32'(branch_o), 32'd0);
        drive_id(base_pc, beq_inst, 32'hdead_0001, make_fwd(1'b1, 5'd9, rf_value(5'd2)));
        compare("pause_o", 32'(pause_o), 32'd0);
        compare("branch_o", 32'(branch_o), 32'd1);
        drive_id(base_pc, ld_inst);
        drive_id(base_pc, {`OP17_ADD_W, 5'd12, 5'd13, 5'd11});
        compare("pause_o", 32'(pause_o), 32'd0);
    endtask

    task automatic branch_test;
        logic [5:0]  ops [6];
        data_t       a;
        data_t       b;
        data_t       pc;
        logic [15:0] off;
        logic [25:0] off26;
        reg_addr_t   rj;
        reg_addr_t   rd;
        logic        taken;
        int          i;
        int          n;
        ops = '{`OP6_BEQ, `OP6_BNE, `OP6_BLT, `OP6_BGE, `OP6_BLTU, `OP6_BGEU};
        drive_id(base_pc, nop_inst);
        for (i = 0; i < 6; i++) begin
            for (n = 0; n < 4; n++) begin
                seed = xorshift(seed);
                a    = seed;
                seed = xorshift(seed);
                // One equal pair per kind
                b    = (n == 0) ? a : seed;
                seed = xorshift(seed);
                off  = seed[15:0];
                seed = xorshift(seed);
                pc   = {seed[31:2], 2'b00};
                rj   = reg_addr_t'(i + 1);
                rd   = reg_addr_t'(n + 16);
                drive_id(pc, write_inst(rj));
                drive_id(pc, {ops[i], off, rj, rd}, a, make_fwd(1'b1, rd, b));
                taken = branch_rule(ops[i], a, b);
                compare("branch_o", 32'(branch_o), 32'(taken));
                compare("flush_o", 32'(flush_o), 32'(taken));
                compare("target_o", target_o, pc + sext16(off));
            end
        end
        seed  = xorshift(seed);
        off26 = seed[25:0];
        drive_id(base_pc, {`OP6_B, off26[15:0], off26[25:16]});
        compare("branch_o", 32'(branch_o), 32'd1);
        compare("target_o", target_o, base_pc + sext26(off26));
        drive_id(base_pc, {`OP6_BL, off26[15:0], off26[25:16]});
        compare("flush_o", 32'(flush_o), 32'd1);
        compare("target_o", target_o, base_pc + sext26(off26));
        drive_id(base_pc, nop_inst);
        verify_link(reg_addr_t'(`LINK_REG), base_pc);
        // jirl r20, r3, off with r3 from EX
        drive_id(base_pc, write_inst(5'd3));
        drive_id(base_pc, {`OP6_JIRL, off, 5'd3, 5'd20}, a);
        compare("branch_o", 32'(branch_o), 32'd1);
        compare("target_o", target_o, a + sext16(off));
        drive_id(base_pc, nop_inst);
        verify_link(5'd20, base_pc);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        pc_i        = '0;
        inst_i      = nop_inst;
        ex_result_i = '0;
        mem_fwd_i   = '0;
        reset_test();
        alu_imm_test();
        store_test();
        forward_test();
        load_use_test();
        branch_test();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Two rising edges under reset, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule
